/* lsu_iq_settings.svh */
`ifndef LSU_IQ_SETTINGS_SVH
`define LSU_IQ_SETTINGS_SVH

// --------------------------------------------------
// load/store issue stage sizing
// --------------------------------------------------

// slots in the in-order issue queue
`define LSU_IQ_SIZE     8

// instructions accepted per dispatch cycle
`define LSU_DISPATCH_W  2

// broadcast ports on the common data bus
`define LSU_CDB_COUNT   2

// --------------------------------------------------
// data memory model
// --------------------------------------------------

// depth in 32-bit words, power of two so the
// index simply wraps
`define LSU_DMEM_WORDS  256

`endif

/* lsu_iq_pkg.sv */
package lsu_iq_pkg;

    typedef logic [31:0] word_t;
    typedef logic [5:0]  rob_id_t;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

    typedef enum logic [1:0] {
        EXC_NONE           = 2'd0,
        EXC_LOAD_MISALIGN  = 2'd1,
        EXC_STORE_MISALIGN = 2'd2
    } exc_code_e;

    // --------------------------------------------------
    // dispatch side
    // --------------------------------------------------
    typedef struct packed {
        rob_id_t   rob_id;
        logic      wmem;
        logic      msigned;
        mem_size_e msize;
        word_t     imm;
        logic      inst_valid;
    } decode_info_t;

    // operand waits on tag until valid
    typedef struct packed {
        word_t   data;
        rob_id_t tag;
        logic    valid;
    } operand_t;

    // src[0] is store data, src[1] is base address
    typedef struct packed {
        decode_info_t   di;
        operand_t [1:0] src;
    } dispatch_t;

    typedef struct packed {
        logic    valid;
        rob_id_t tag;
        word_t   data;
    } cdb_t;

    // --------------------------------------------------
    // memory side
    // --------------------------------------------------
    typedef struct packed {
        word_t     vaddr;
        word_t     wdata;
        logic [3:0] strb;
        logic [3:0] rmask;
        logic      wmem;
        logic      msigned;
        mem_size_e msize;
        rob_id_t   rob_id;
    } mem_req_t;

    typedef struct packed {
        word_t     rdata;
        logic      exc_valid;
        exc_code_e exc_code;
        word_t     badv;
    } mem_resp_t;

    typedef struct packed {
        rob_id_t   rob_id;
        word_t     rdata;
        logic      is_store;
        logic      exc_valid;
        exc_code_e exc_code;
        word_t     badv;
    } lsu_result_t;

endpackage

/* iq_entry.sv */
`timescale 1ns/1ps
`include "lsu_iq_settings.svh"

module iq_entry (
    input  logic                                      clk,
    input  logic                                      arst_n_i,
    input  logic                                      flush_i,
    input  logic                                      init_i,
    input  lsu_iq_pkg::dispatch_t                     disp_i,
    input  lsu_iq_pkg::cdb_t [`LSU_CDB_COUNT-1:0]    cdb_i,
    input  logic                                      select_i,
    output logic                                      ready_o,
    output lsu_iq_pkg::decode_info_t                  di_o,
    output lsu_iq_pkg::word_t [1:0]                   data_o
);
    import lsu_iq_pkg::*;

    logic           occupied_q;
    decode_info_t   di_q;
    operand_t [1:0] src_q;
    operand_t [1:0] src_nxt;

    // capture a broadcast into a waiting operand
    function automatic operand_t wake(input operand_t op,
                                      input cdb_t [`LSU_CDB_COUNT-1:0] cdb);
        operand_t res;
        res = op;
        for (int c = 0; c < `LSU_CDB_COUNT; c++) begin
            if (!op.valid && cdb[c].valid && (cdb[c].tag == op.tag)) begin
                res.data  = cdb[c].data;
                res.valid = 1'b1;
            end
        end
        return res;
    endfunction

    // --------------------------------------------------
    // operand update
    // --------------------------------------------------
    // new instruction sees the same-cycle broadcast too
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            src_nxt[k] = wake(init_i ? disp_i.src[k] : src_q[k], cdb_i);
        end
    end

    always_ff @(posedge clk) begin
        if (init_i) begin
            di_q <= disp_i.di;
        end
        src_q <= src_nxt;
    end

    // --------------------------------------------------
    // slot occupancy
    // --------------------------------------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            occupied_q <= 1'b0;
        end else if (flush_i) begin
            occupied_q <= 1'b0;
        end else if (init_i) begin
            occupied_q <= 1'b1;
        end else if (select_i) begin
            occupied_q <= 1'b0;
        end
    end

    assign ready_o   = occupied_q & src_q[0].valid & src_q[1].valid;
    assign di_o      = di_q;
    assign data_o[0] = src_q[0].data;
    assign data_o[1] = src_q[1].data;

endmodule

/* lsu_iq.sv */
`timescale 1ns/1ps
`include "lsu_iq_settings.svh"

module lsu_iq #(
    parameter int IQ_SIZE = `LSU_IQ_SIZE
) (
    input  logic                                        clk,
    input  logic                                        arst_n_i,
    input  logic                                        flush_i,
    input  logic [`LSU_DISPATCH_W-1:0]                  disp_valid_i,
    input  lsu_iq_pkg::dispatch_t [`LSU_DISPATCH_W-1:0] disp_i,
    output logic                                        entry_ready_o,
    input  lsu_iq_pkg::cdb_t [`LSU_CDB_COUNT-1:0]      cdb_i,
    output logic                                        req_valid_o,
    input  logic                                        req_ready_i,
    output lsu_iq_pkg::mem_req_t                        req_o
);
    import lsu_iq_pkg::*;

    localparam int PTR_W = (IQ_SIZE > 1) ? $clog2(IQ_SIZE) : 1;
    localparam int CNT_W = $clog2(IQ_SIZE + 1);

    logic [PTR_W-1:0] head_q, head_nxt;
    logic [PTR_W-1:0] tail_q, tail_nxt;
    logic [CNT_W-1:0] free_q, free_nxt;
    logic [CNT_W-1:0] disp_cnt;

    logic [IQ_SIZE-1:0] entry_init;
    logic [IQ_SIZE-1:0] entry_ready;
    dispatch_t          entry_disp [IQ_SIZE];
    decode_info_t       entry_di   [IQ_SIZE];
    word_t [1:0]        entry_data [IQ_SIZE];

    logic         head_ready;
    logic         iss_ready;
    logic         issue_fire;
    logic         iss_valid_q;
    decode_info_t iss_di_q;
    word_t [1:0]  iss_data_q;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(IQ_SIZE - 1)) begin
            return '0;
        end else begin
            return p + 1'b1;
        end
    endfunction

    // --------------------------------------------------
    // dispatch placement
    // --------------------------------------------------
    // valid slots fill consecutive tail entries, slot 0 first
    always_comb begin : disp_place
        logic [PTR_W-1:0] slot;
        entry_init = '0;
        disp_cnt   = '0;
        slot       = tail_q;
        for (int i = 0; i < IQ_SIZE; i++) begin
            entry_disp[i] = disp_i[0];
        end
        for (int k = 0; k < `LSU_DISPATCH_W; k++) begin
            if (entry_ready_o && disp_valid_i[k]) begin
                entry_init[slot] = 1'b1;
                entry_disp[slot] = disp_i[k];
                slot             = ptr_inc(slot);
                disp_cnt         = disp_cnt + 1'b1;
            end
        end
        tail_nxt = slot;
    end

    assign head_nxt = issue_fire ? ptr_inc(head_q) : head_q;
    assign free_nxt = free_q - disp_cnt + CNT_W'(issue_fire);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head_q        <= '0;
            tail_q        <= '0;
            free_q        <= CNT_W'(IQ_SIZE);
            entry_ready_o <= 1'b1;
        end else if (flush_i) begin
            head_q        <= '0;
            tail_q        <= '0;
            free_q        <= CNT_W'(IQ_SIZE);
            entry_ready_o <= 1'b1;
        end else begin
            head_q        <= head_nxt;
            tail_q        <= tail_nxt;
            free_q        <= free_nxt;
            // room for a full dispatch group next cycle
            entry_ready_o <= (free_nxt >= CNT_W'(`LSU_DISPATCH_W));
        end
    end

    // --------------------------------------------------
    // queue slots
    // --------------------------------------------------
    for (genvar i = 0; i < IQ_SIZE; i++) begin : g_entry
        iq_entry u_entry (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .flush_i  (flush_i),
            .init_i   (entry_init[i]),
            .disp_i   (entry_disp[i]),
            .cdb_i    (cdb_i),
            .select_i (issue_fire && (head_q == PTR_W'(i))),
            .ready_o  (entry_ready[i]),
            .di_o     (entry_di[i]),
            .data_o   (entry_data[i])
        );
    end

    // --------------------------------------------------
    // in-order issue
    // --------------------------------------------------
    assign head_ready = entry_ready[head_q];
    assign iss_ready  = !iss_valid_q || req_ready_i;
    assign issue_fire = head_ready && iss_ready;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            iss_valid_q <= 1'b0;
        end else if (flush_i) begin
            iss_valid_q <= 1'b0;
        end else if (iss_ready) begin
            iss_valid_q <= head_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            iss_di_q   <= entry_di[head_q];
            iss_data_q <= entry_data[head_q];
        end
    end

    // --------------------------------------------------
    // request formatting
    // --------------------------------------------------
    word_t      vaddr;
    logic [3:0] size_pat;
    logic [3:0] byte_mask;

    always_comb begin
        vaddr = iss_data_q[1] + iss_di_q.imm;
        case (iss_di_q.msize)
            MEM_BYTE: size_pat = 4'b0001;
            MEM_HALF: size_pat = 4'b0011;
            default:  size_pat = 4'b1111;
        endcase
        byte_mask = size_pat << vaddr[1:0];

        req_o         = '0;
        req_o.vaddr   = vaddr;
        // store data moves into its byte lane
        req_o.wdata   = iss_data_q[0] << {vaddr[1:0], 3'b000};
        req_o.strb    = iss_di_q.wmem ? byte_mask : 4'b0000;
        req_o.rmask   = iss_di_q.wmem ? 4'b0000 : byte_mask;
        req_o.wmem    = iss_di_q.wmem;
        req_o.msigned = iss_di_q.msigned;
        req_o.msize   = iss_di_q.msize;
        req_o.rob_id  = iss_di_q.rob_id;
    end

    assign req_valid_o = iss_valid_q;

endmodule

/* lsu_dmem.sv */
`timescale 1ns/1ps
`include "lsu_iq_settings.svh"

module lsu_dmem (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    flush_i,
    input  logic                    req_valid_i,
    output logic                    req_ready_o,
    input  lsu_iq_pkg::mem_req_t    req_i,
    output logic                    result_valid_o,
    input  logic                    result_ready_i,
    output lsu_iq_pkg::lsu_result_t result_o
);
    import lsu_iq_pkg::*;

    localparam int IDX_W = $clog2(`LSU_DMEM_WORDS);

    word_t            mem_q [`LSU_DMEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             accept;
    logic             misalign;
    word_t            rd_masked;
    word_t            rd_shift;
    word_t            rd_ext;
    mem_resp_t        resp;
    logic             resp_valid_q;
    lsu_result_t      res_q;

    assign idx         = req_i.vaddr[IDX_W+1:2];
    assign req_ready_o = !resp_valid_q || result_ready_i;
    assign accept      = req_valid_i && req_ready_o && !flush_i;
    assign misalign    = ((req_i.msize == MEM_HALF) && req_i.vaddr[0]) ||
                         ((req_i.msize == MEM_WORD) && (|req_i.vaddr[1:0]));

    // --------------------------------------------------
    // storage with byte enables
    // --------------------------------------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int w = 0; w < `LSU_DMEM_WORDS; w++) begin
                mem_q[w] <= '0;
            end
        end else if (accept && req_i.wmem && !misalign) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.strb[b]) begin
                    mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // load path, pick the lanes then extend
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            rd_masked[8*b +: 8] = req_i.rmask[b] ? mem_q[idx][8*b +: 8] : 8'h00;
        end
        rd_shift = rd_masked >> {req_i.vaddr[1:0], 3'b000};
        case (req_i.msize)
            MEM_BYTE: rd_ext = {{24{req_i.msigned & rd_shift[7]}}, rd_shift[7:0]};
            MEM_HALF: rd_ext = {{16{req_i.msigned & rd_shift[15]}}, rd_shift[15:0]};
            default:  rd_ext = rd_masked;
        endcase

        resp           = '0;
        resp.rdata     = (req_i.wmem || misalign) ? '0 : rd_ext;
        resp.exc_valid = misalign;
        resp.exc_code  = !misalign   ? EXC_NONE :
                         req_i.wmem  ? EXC_STORE_MISALIGN : EXC_LOAD_MISALIGN;
        resp.badv      = misalign ? req_i.vaddr : '0;
    end

    // --------------------------------------------------
    // response register, held until taken
    // --------------------------------------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            resp_valid_q <= 1'b0;
        end else if (flush_i) begin
            resp_valid_q <= 1'b0;
        end else if (req_ready_o) begin
            resp_valid_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            res_q.rob_id    <= req_i.rob_id;
            res_q.rdata     <= resp.rdata;
            res_q.is_store  <= req_i.wmem;
            res_q.exc_valid <= resp.exc_valid;
            res_q.exc_code  <= resp.exc_code;
            res_q.badv      <= resp.badv;
        end
    end

    assign result_valid_o = resp_valid_q;
    assign result_o       = res_q;

endmodule

/* lsu_subsys_top.sv */
`timescale 1ns/1ps
`include "lsu_iq_settings.svh"

module lsu_subsys_top (
    input  logic                                        clk,
    input  logic                                        arst_n_i,
    input  logic                                        flush_i,
    input  logic [`LSU_DISPATCH_W-1:0]                  disp_valid_i,
    input  lsu_iq_pkg::dispatch_t [`LSU_DISPATCH_W-1:0] disp_i,
    output logic                                        entry_ready_o,
    input  lsu_iq_pkg::cdb_t [`LSU_CDB_COUNT-1:0]      cdb_i,
    output logic                                        result_valid_o,
    input  logic                                        result_ready_i,
    output lsu_iq_pkg::lsu_result_t                     result_o
);
    import lsu_iq_pkg::*;

    // --------------------------------------------------
    // queue to memory request channel
    // --------------------------------------------------
    logic     req_valid;
    logic     req_ready;
    mem_req_t req;

    lsu_iq #(
        .IQ_SIZE (`LSU_IQ_SIZE)
    ) u_iq (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .flush_i       (flush_i),
        .disp_valid_i  (disp_valid_i),
        .disp_i        (disp_i),
        .entry_ready_o (entry_ready_o),
        .cdb_i         (cdb_i),
        .req_valid_o   (req_valid),
        .req_ready_i   (req_ready),
        .req_o         (req)
    );

    // stands in for the data cache
    lsu_dmem u_dmem (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .flush_i        (flush_i),
        .req_valid_i    (req_valid),
        .req_ready_o    (req_ready),
        .req_i          (req),
        .result_valid_o (result_valid_o),
        .result_ready_i (result_ready_i),
        .result_o       (result_o)
    );

endmodule

/* lsu_subsys_chk.sv */
`timescale 1ns/1ps

module lsu_subsys_chk (
    input logic                    clk,
    input logic                    arst_n_i,
    input logic                    flush_i,
    input logic                    req_valid,
    input logic                    req_ready,
    input lsu_iq_pkg::mem_req_t    req,
    input logic                    result_valid_o,
    input logic                    result_ready_i,
    input lsu_iq_pkg::lsu_result_t result_o
);
    import lsu_iq_pkg::*;

    // count of assertion failures
    int fail_cnt = 0;

    // --------------------------------------------------
    // handshake stability
    // --------------------------------------------------
    a_req_stable: assert property (@(posedge clk) disable iff (!arst_n_i || flush_i)
        req_valid && !req_ready |=> req_valid && $stable(req))
        else begin
            $error("memory request changed before it was accepted");
            fail_cnt++;
        end

    a_res_stable: assert property (@(posedge clk) disable iff (!arst_n_i || flush_i)
        result_valid_o && !result_ready_i |=> result_valid_o && $stable(result_o))
        else begin
            $error("result changed before it was taken");
            fail_cnt++;
        end

    // reset keeps both channels idle
    a_reset_idle: assert property (@(posedge clk)
        !arst_n_i |-> !req_valid && !result_valid_o)
        else begin
            $error("valid high during reset");
            fail_cnt++;
        end

    a_load_strb: assert property (@(posedge clk) disable iff (!arst_n_i)
        req_valid && !req.wmem |-> req.strb == 4'b0000)
        else begin
            $error("load request carries a write strobe");
            fail_cnt++;
        end

endmodule

bind lsu_subsys_top lsu_subsys_chk chk_i (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .flush_i        (flush_i),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .req            (req),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i),
    .result_o       (result_o)
);

/* tb_lsu_scoreboard.sv */
`timescale 1ns/1ps

module tb_lsu_scoreboard (
    input logic                    clk,
    input logic                    arst_n_i,
    input logic                    result_valid_i,
    input logic                    result_ready_i,
    input lsu_iq_pkg::lsu_result_t result_i
);
    import lsu_iq_pkg::*;

    // expected results in program order, filled by the testbench
    lsu_result_t exp_q [$];
    int          checked_cnt = 0;
    int          err_cnt = 0;

    function automatic void compare_field(input string name, input word_t got,
                                          input word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns result_o.%s: got %h expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endfunction

    // --------------------------------------------------
    // compare every accepted result
    // --------------------------------------------------
    always @(posedge clk) begin : watch
        lsu_result_t exp;
        if (arst_n_i && result_valid_i && result_ready_i) begin
            if (exp_q.size() == 0) begin
                $display("%0t ns: a result for rob id %0d came out with none expected",
                         $time, result_i.rob_id);
                err_cnt++;
            end else begin
                exp = exp_q.pop_front();
                compare_field("rob_id", word_t'(result_i.rob_id), word_t'(exp.rob_id));
                compare_field("rdata", result_i.rdata, exp.rdata);
                compare_field("is_store", word_t'(result_i.is_store), word_t'(exp.is_store));
                compare_field("exc_valid", word_t'(result_i.exc_valid),
                              word_t'(exp.exc_valid));
                compare_field("exc_code", word_t'(result_i.exc_code), word_t'(exp.exc_code));
                compare_field("badv", result_i.badv, exp.badv);
                checked_cnt++;
            end
        end
    end

endmodule

/* tb_lsu_subsys.sv */
`timescale 1ns/1ps
`include "lsu_iq_settings.svh"

module tb_lsu_subsys;
    import lsu_iq_pkg::*;

    localparam int TIMEOUT = 2000;

    logic                             clk;
    logic                             arst_n_i;
    logic                             flush_i;
    logic [`LSU_DISPATCH_W-1:0]       disp_valid_i;
    dispatch_t [`LSU_DISPATCH_W-1:0]  disp_i;
    logic                             entry_ready_o;
    cdb_t [`LSU_CDB_COUNT-1:0]        cdb_i;
    logic                             result_valid_o;
    logic                             result_ready_i;
    lsu_result_t                      result_o;

    integer  seed;
    logic    random_bp;
    logic    hold_bp;
    rob_id_t next_rob;
    word_t   shadow [`LSU_DMEM_WORDS];
    int      tb_errors;

    lsu_subsys_top dut_i (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .flush_i        (flush_i),
        .disp_valid_i   (disp_valid_i),
        .disp_i         (disp_i),
        .entry_ready_o  (entry_ready_o),
        .cdb_i          (cdb_i),
        .result_valid_o (result_valid_o),
        .result_ready_i (result_ready_i),
        .result_o       (result_o)
    );

    tb_lsu_scoreboard sb_i (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .result_valid_i (result_valid_o),
        .result_ready_i (result_ready_i),
        .result_i       (result_o)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // result back-pressure, held off or random only where a test asks
    always @(negedge clk) begin
        result_ready_i = hold_bp ? 1'b0 : random_bp ? 1'($random(seed)) : 1'b1;
    end

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    function automatic void ref_access(input decode_info_t di, input word_t op0,
                                       input word_t op1);
        lsu_result_t exp;
        word_t       addr;
        word_t       a;
        word_t       val;
        int          nbytes;
        nbytes = (di.msize == MEM_BYTE) ? 1 : (di.msize == MEM_HALF) ? 2 : 4;
        addr = op1 + di.imm;
        exp = '0;
        exp.rob_id = di.rob_id;
        exp.is_store = di.wmem;
        if ((addr % nbytes) != 0) begin
            exp.exc_valid = 1'b1;
            exp.exc_code = di.wmem ? EXC_STORE_MISALIGN : EXC_LOAD_MISALIGN;
            exp.badv = addr;
        end else if (di.wmem) begin
            for (int i = 0; i < nbytes; i++) begin
                a = addr + i;
                shadow[(a >> 2) % `LSU_DMEM_WORDS][8*(a % 4) +: 8] = op0[8*i +: 8];
            end
        end else begin
            val = '0;
            for (int i = 0; i < nbytes; i++) begin
                a = addr + i;
                val[8*i +: 8] = shadow[(a >> 2) % `LSU_DMEM_WORDS][8*(a % 4) +: 8];
            end
            for (int j = 8 * nbytes; j < 32; j++) begin
                val[j] = di.msigned & val[8*nbytes-1];
            end
            exp.rdata = val;
        end
        sb_i.exp_q.push_back(exp);
    endfunction

    function automatic operand_t ready_op(input word_t val);
        return '{data: val, tag: '0, valid: 1'b1};
    endfunction

    function automatic operand_t wait_op(input rob_id_t tag);
        return '{data: '0, tag: tag, valid: 1'b0};
    endfunction

    function automatic dispatch_t new_instr(input logic wmem, input logic msigned,
                                            input mem_size_e msize, input word_t imm,
                                            input operand_t op0, input operand_t op1);
        dispatch_t d;
        d.di = '{rob_id: next_rob, wmem: wmem, msigned: msigned, msize: msize,
                 imm: imm, inst_valid: 1'b1};
        d.src[0] = op0;
        d.src[1] = op1;
        next_rob = next_rob + 1'b1;
        return d;
    endfunction

    // errors from the scoreboard, the testbench and the bound assertions
    function automatic int error_count();
        return sb_i.err_cnt + tb_errors + dut_i.chk_i.fail_cnt;
    endfunction

    // --------------------------------------------------
    // stimulus tasks, called on a falling edge
    // --------------------------------------------------
    task automatic wait_room();
        int n;
        n = 0;
        while (!entry_ready_o) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                $display("timeout: entry_ready_o stayed low");
                $display("** FAIL **");
                $finish;
            end
        end
    endtask

    // cdb_i may be set by the caller for a same-cycle broadcast
    task automatic send_one(input int slot, input dispatch_t d, input word_t v0,
                            input word_t v1, input bit model);
        wait_room();
        disp_i[slot] = d;
        disp_valid_i[slot] = 1'b1;
        if (model) begin
            ref_access(d.di, v0, v1);
        end
        @(negedge clk);
        disp_valid_i = '0;
        cdb_i = '0;
    endtask

    task automatic send_pair(input dispatch_t d0, input word_t a0, input word_t a1,
                             input dispatch_t d1, input word_t b0, input word_t b1);
        wait_room();
        disp_i[0] = d0;
        disp_i[1] = d1;
        disp_valid_i = 2'b11;
        ref_access(d0.di, a0, a1);
        ref_access(d1.di, b0, b1);
        @(negedge clk);
        disp_valid_i = '0;
        cdb_i = '0;
    endtask

    task automatic broadcast(input int port, input rob_id_t tag, input word_t data);
        cdb_i[port] = '{valid: 1'b1, tag: tag, data: data};
        @(negedge clk);
        cdb_i = '0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (sb_i.exp_q.size() != 0) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                $display("timeout: %0d results never arrived", sb_i.exp_q.size());
                $display("** FAIL **");
                $finish;
            end
        end
    endtask

    task automatic report(input string name);
        $display("test %s done, %0d results checked, %0d errors so far", name,
                 sb_i.checked_cnt, error_count());
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin : main
        dispatch_t d0;
        dispatch_t d1;
        word_t     val;
        word_t     a0;
        word_t     a1;
        int        nb;
        int        off;
        mem_size_e sz0;
        mem_size_e sz1;
        seed = 32'h12ce;
        random_bp = 1'b0;
        hold_bp = 1'b0;
        next_rob = '0;
        tb_errors = 0;
        arst_n_i = 1'b0;
        flush_i = 1'b0;
        disp_valid_i = '0;
        disp_i = '0;
        cdb_i = '0;
        result_ready_i = 1'b1;
        for (int w = 0; w < `LSU_DMEM_WORDS; w++) begin
            shadow[w] = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        @(negedge clk);

        // store then load, every size and aligned offset
        for (int s = 0; s < 3; s++) begin
            nb = 1 << s;
            for (off = 0; off < 4; off += nb) begin
                val = $random(seed);
                d0 = new_instr(1'b1, 1'b0, mem_size_e'(s), off, ready_op(val),
                               ready_op(32'h40 + 16 * s));
                send_one(0, d0, val, 32'h40 + 16 * s, 1'b1);
                d0 = new_instr(1'b0, 1'b0, mem_size_e'(s), off, ready_op(0),
                               ready_op(32'h40 + 16 * s));
                d1 = new_instr(1'b0, 1'b1, mem_size_e'(s), off, ready_op(0),
                               ready_op(32'h40 + 16 * s));
                send_pair(d0, 0, 32'h40 + 16 * s, d1, 0, 32'h40 + 16 * s);
            end
        end
        d0 = new_instr(1'b0, 1'b1, MEM_BYTE, 3, ready_op(0), ready_op(32'h40));
        send_one(1, d0, 0, 32'h40, 1'b1);
        wait_drain();
        report("1 store/load sizes");

        // tag wakeup on both CDB ports
        d0 = new_instr(1'b1, 1'b0, MEM_WORD, 0, wait_op(6'd10), ready_op(32'h100));
        d1 = new_instr(1'b0, 1'b1, MEM_HALF, 2, ready_op(0), wait_op(6'd11));
        send_pair(d0, 32'hA5A5_9234, 32'h100, d1, 0, 32'h100);
        repeat (2) @(negedge clk);
        broadcast(0, 6'd10, 32'hA5A5_9234);
        broadcast(1, 6'd11, 32'h100);
        cdb_i[1] = '{valid: 1'b1, tag: 6'd12, data: 32'h108};
        d0 = new_instr(1'b1, 1'b0, MEM_BYTE, 1, ready_op(32'h7f), wait_op(6'd12));
        send_one(0, d0, 32'h7f, 32'h108, 1'b1);
        d0 = new_instr(1'b0, 1'b0, MEM_WORD, 0, ready_op(0), ready_op(32'h108));
        send_one(0, d0, 0, 32'h108, 1'b1);
        wait_drain();
        report("2 CDB wakeup");

        // misaligned accesses leave memory alone
        d0 = new_instr(1'b1, 1'b0, MEM_WORD, 0, ready_op(32'h1122_3344), ready_op(32'h200));
        d1 = new_instr(1'b1, 1'b0, MEM_HALF, 1, ready_op(32'hffff), ready_op(32'h200));
        send_pair(d0, 32'h1122_3344, 32'h200, d1, 32'hffff, 32'h200);
        d0 = new_instr(1'b1, 1'b0, MEM_WORD, 2, ready_op(32'hdead), ready_op(32'h200));
        d1 = new_instr(1'b0, 1'b1, MEM_HALF, 3, ready_op(0), ready_op(32'h200));
        send_pair(d0, 32'hdead, 32'h200, d1, 0, 32'h200);
        d0 = new_instr(1'b0, 1'b0, MEM_WORD, 6, ready_op(0), ready_op(32'h200));
        d1 = new_instr(1'b0, 1'b0, MEM_WORD, 0, ready_op(0), ready_op(32'h200));
        send_pair(d0, 0, 32'h200, d1, 0, 32'h200);
        wait_drain();
        report("3 misalignment");

        // dual dispatch bursts under random back-pressure
        random_bp = 1'b1;
        for (int i = 0; i < 24; i++) begin
            sz0 = mem_size_e'($unsigned($random(seed)) % 3);
            sz1 = mem_size_e'($unsigned($random(seed)) % 3);
            a0 = 32'h300 + (($random(seed) & 63) << 2);
            a1 = 32'h300 + (($random(seed) & 63) << 2);
            off = $random(seed) & 3;
            val = $random(seed);
            d0 = new_instr(val[0], val[1], sz0, off & ~((1 << sz0) - 1),
                           ready_op(val), ready_op(a0));
            d1 = new_instr(val[2], val[3], sz1, 0, ready_op(~val), ready_op(a1));
            send_pair(d0, val, a0, d1, ~val, a1);
        end
        wait_drain();
        random_bp = 1'b0;
        report("4 back-pressure");

        // flush drops a held result, the issue register and waiting stores
        d0 = new_instr(1'b1, 1'b0, MEM_WORD, 0, ready_op(32'hcafe_f00d), ready_op(32'h80));
        d1 = new_instr(1'b1, 1'b0, MEM_BYTE, 1, ready_op(32'h5a), ready_op(32'h84));
        send_pair(d0, 32'hcafe_f00d, 32'h80, d1, 32'h5a, 32'h84);
        wait_drain();
        hold_bp = 1'b1;
        for (int i = 0; i < 3; i++) begin
            d0 = new_instr(1'b0, 1'b0, MEM_WORD, 0, ready_op(0), ready_op(32'h80));
            send_one(0, d0, 0, 0, 1'b0);
        end
        for (int i = 0; i < 6; i++) begin
            d0 = new_instr(1'b1, 1'b0, MEM_WORD, 0, ready_op(32'hbad0 + i), wait_op(6'd40));
            send_one(i % 2, d0, 0, 0, 1'b0);
        end
        repeat (3) @(negedge clk);
        // one slot left, so no room for a full group
        if (entry_ready_o !== 1'b0) begin
            $display("[ERROR] %0t ns entry_ready_o: got %b expected 0", $time, entry_ready_o);
            tb_errors++;
        end
        flush_i = 1'b1;
        @(negedge clk);
        flush_i = 1'b0;
        hold_bp = 1'b0;
        if (entry_ready_o !== 1'b1) begin
            $display("[ERROR] %0t ns entry_ready_o: got %b expected 1", $time, entry_ready_o);
            tb_errors++;
        end
        broadcast(0, 6'd40, 32'h80);
        repeat (10) @(negedge clk);
        d0 = new_instr(1'b0, 1'b0, MEM_WORD, 0, ready_op(0), ready_op(32'h80));
        d1 = new_instr(1'b0, 1'b0, MEM_WORD, 0, ready_op(0), ready_op(32'h84));
        send_pair(d0, 0, 32'h80, d1, 0, 32'h84);
        wait_drain();
        report("5 flush");

        repeat (5) @(negedge clk);
        $display("%0d results checked, %0d errors", sb_i.checked_cnt, error_count());
        if (error_count() == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* lsu_subsys.f */
+incdir+.
lsu_iq_pkg.sv
iq_entry.sv
lsu_iq.sv
lsu_dmem.sv
lsu_subsys_top.sv
lsu_subsys_chk.sv
tb_lsu_scoreboard.sv
tb_lsu_subsys.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the load/store subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu_subsys \
    -f lsu_subsys.f > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vtb_lsu_subsys > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log

grep -q '\*\* FAIL \*\*' sim.log && { echo "simulation failed"; exit 1; } || \
    grep -q '\*\* PASS \*\*' sim.log && { echo "simulation passed"; exit 0; } || \
    { echo "simulation ended without a verdict"; exit 1; }
